//--- rtl/hub75_pkg.sv
package hub75_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // panel geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int PANEL_COLS = 16;
  localparam int SCAN_ROWS  = 32;
  localparam int PLANES     = 4;
  localparam int FB_DEPTH   = 1024;

  localparam int COL_W   = $clog2(PANEL_COLS);
  localparam int ROW_W   = $clog2(SCAN_ROWS);
  localparam int PLANE_W = $clog2(PLANES);
  localparam int FB_AW   = $clog2(FB_DEPTH);

  localparam logic [ROW_W-1:0]   LAST_ROW   = ROW_W'(SCAN_ROWS - 1);
  localparam logic [PLANE_W-1:0] LAST_PLANE = PLANE_W'(PLANES - 1);

  // two clk per column, two more for the read pipeline
  localparam int SHIFT_STEPS = 2 * PANEL_COLS + 2;
  localparam int STEP_W      = $clog2(SHIFT_STEPS + 1);
  localparam logic [STEP_W-1:0] LAST_LOAD = STEP_W'(2 * PANEL_COLS);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(SHIFT_STEPS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // BCM timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int BCM_BASE  = 8;
  localparam int BCM_CNT_W = $clog2((BCM_BASE << (PLANES - 1)) + 1);
  localparam logic [BCM_CNT_W-1:0] BCM_BASE_CNT = BCM_CNT_W'(BCM_BASE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pixel_t;

  typedef struct packed {
    logic r1;
    logic g1;
    logic b1;
    logic r2;
    logic g2;
    logic b2;
  } rgb_bits_t;

  typedef struct packed {
    logic enable;
    logic dim;
  } panel_ctrl_t;

  typedef struct packed {
    rgb_bits_t        rgb;
    logic             sclk;
    logic             lat;
    logic             oe_n;
    logic [ROW_W-1:0] row;
  } hub75_out_t;

  typedef enum logic [2:0] {
    SCAN_IDLE,
    SCAN_FIRST_SHIFT,
    SCAN_WAIT,
    SCAN_LATCH,
    SCAN_NEXT_ROW
  } scan_state_t;

endpackage

//--- rtl/wb_pkg.sv
package wb_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat_r;
    logic        ack;
  } wb_rsp_t;

  // byte offsets
  localparam logic [3:0] REG_CTRL    = 4'h0;
  localparam logic [3:0] REG_STATUS  = 4'h4;
  localparam logic [3:0] REG_FB_ADDR = 4'h8;
  localparam logic [3:0] REG_FB_DATA = 4'hc;

  localparam int FRAME_CNT_W = 16;

endpackage

//--- rtl/panel_regs.sv
module panel_regs (
  input  logic                           clk,
  input  logic                           rst,
  input  wb_pkg::wb_req_t                wb_req,
  output wb_pkg::wb_rsp_t                wb_rsp,
  output hub75_pkg::panel_ctrl_t         ctrl,
  input  logic                           frame_tick,
  output logic                           fb_we,
  output logic [hub75_pkg::FB_AW-1:0]    fb_waddr,
  output hub75_pkg::pixel_t              fb_wdata
);

  logic                           ack;
  logic                           ack_hold;
  logic                           ack_next;
  logic                           wr_en;
  logic                           lo_half;
  logic [31:0]                    dat_r;
  logic [wb_pkg::FRAME_CNT_W-1:0] frame_count;
  logic [hub75_pkg::FB_AW-1:0]    fb_addr;

  // one ack per strobe, then wait for stb to drop
  assign ack_next = wb_req.cyc && wb_req.stb && !ack && !ack_hold;
  assign wr_en    = ack_next && wb_req.we;
  assign lo_half  = &wb_req.sel[1:0];

  assign fb_we    = wr_en && lo_half && (wb_req.adr == wb_pkg::REG_FB_DATA);
  assign fb_waddr = fb_addr;
  assign fb_wdata = wb_req.dat_w[11:0];

  assign wb_rsp.dat_r = dat_r;
  assign wb_rsp.ack   = ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack         <= 1'b0;
      ack_hold    <= 1'b0;
      ctrl        <= '0;
      fb_addr     <= '0;
      frame_count <= '0;
    end else begin
      ack      <= ack_next;
      ack_hold <= wb_req.cyc && wb_req.stb && (ack_hold || ack);

      if (frame_tick) begin
        frame_count <= frame_count + 1'b1;
      end

      if (wr_en && wb_req.sel[0] && wb_req.adr == wb_pkg::REG_CTRL) begin
        ctrl.enable <= wb_req.dat_w[0];
        ctrl.dim    <= wb_req.dat_w[1];
      end

      // pixel writes step the window address
      if (fb_we) begin
        fb_addr <= fb_addr + 1'b1;
      end else if (wr_en && lo_half && wb_req.adr == wb_pkg::REG_FB_ADDR) begin
        fb_addr <= wb_req.dat_w[hub75_pkg::FB_AW-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ack_next) begin
      case (wb_req.adr)
        wb_pkg::REG_CTRL:    dat_r <= {30'd0, ctrl.dim, ctrl.enable};
        wb_pkg::REG_STATUS:  dat_r <= 32'(frame_count);
        wb_pkg::REG_FB_ADDR: dat_r <= 32'(fb_addr);
        default:             dat_r <= '0;
      endcase
    end
  end

endmodule

//--- rtl/frame_buffer.sv
module frame_buffer (
  input  logic                        clk,
  input  logic                        we,
  input  logic [hub75_pkg::FB_AW-1:0] waddr,
  input  hub75_pkg::pixel_t           wdata,
  input  logic [hub75_pkg::FB_AW-1:0] raddr,
  output hub75_pkg::pixel_t           rdata
);

  // address is {half, row, col}
  hub75_pkg::pixel_t mem [hub75_pkg::FB_DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port, bus side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port, shifter side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registered, one cycle latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

//--- rtl/row_shifter.sv
module row_shifter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          shift_start,
  input  logic [hub75_pkg::ROW_W-1:0]   row,
  input  logic [hub75_pkg::PLANE_W-1:0] plane,
  output logic [hub75_pkg::FB_AW-1:0]   raddr,
  input  hub75_pkg::pixel_t             rdata,
  output hub75_pkg::rgb_bits_t          rgb,
  output logic                          sclk,
  output logic                          shift_done
);

  logic                           busy;
  logic [hub75_pkg::STEP_W-1:0]   step;
  logic [hub75_pkg::STEP_W-1:0]   rd_step;
  logic [hub75_pkg::ROW_W-1:0]    row_q;
  logic [hub75_pkg::ROW_W-1:0]    rd_row;
  logic [hub75_pkg::PLANE_W-1:0]  plane_q;
  hub75_pkg::pixel_t              upper_q;

  // step 0 is the start cycle itself, so the first read goes out at once
  assign rd_step = shift_start ? '0 : step;
  assign rd_row  = shift_start ? row : row_q;
  // even steps read the upper half, odd steps the lower half
  assign raddr   = {rd_step[0], rd_row, rd_step[hub75_pkg::COL_W:1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      step       <= '0;
      sclk       <= 1'b0;
      shift_done <= 1'b0;
    end else begin
      shift_done <= busy && (step == hub75_pkg::LAST_STEP - 1'b1);
      if (shift_start) begin
        busy <= 1'b1;
        step <= 1;
      end else if (busy) begin
        step <= step + 1'b1;
        // low on the data cycle, high on the next
        if (step > 2) begin
          sclk <= step[0];
        end
        if (step == hub75_pkg::LAST_STEP) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (shift_start) begin
      row_q   <= row;
      plane_q <= plane;
    end
    if (busy && step[0]) begin
      upper_q <= rdata;
    end else if (busy && step > 1 && step <= hub75_pkg::LAST_LOAD) begin
      // upper half held, lower half arriving now
      rgb.r1 <= upper_q.r[plane_q];
      rgb.g1 <= upper_q.g[plane_q];
      rgb.b1 <= upper_q.b[plane_q];
      rgb.r2 <= rdata.r[plane_q];
      rgb.g2 <= rdata.g[plane_q];
      rgb.b2 <= rdata.b[plane_q];
    end
  end

endmodule

//--- rtl/bcm_timer.sv
module bcm_timer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          show_start,
  input  logic [hub75_pkg::PLANE_W-1:0] plane,
  input  logic                          dim,
  output logic                          oe_n,
  output logic                          show_done
);

  logic [hub75_pkg::BCM_CNT_W-1:0] cnt;
  logic [hub75_pkg::BCM_CNT_W-1:0] full_time;
  logic [hub75_pkg::BCM_CNT_W-1:0] on_time;

  // binary weight per plane, dim halves it
  assign full_time = hub75_pkg::BCM_BASE_CNT << plane;
  assign on_time   = dim ? (full_time >> 1) : full_time;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt       <= '0;
      oe_n      <= 1'b1;
      show_done <= 1'b0;
    end else begin
      show_done <= 1'b0;
      if (show_start) begin
        cnt  <= on_time;
        oe_n <= 1'b0;
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == 1) begin
          oe_n      <= 1'b1;
          show_done <= 1'b1;
        end
      end
    end
  end

  // sequencer must wait for the previous display
  a_no_restart : assert property (
    @(posedge clk) disable iff (rst) show_start |-> cnt == '0
  ) else $error("show_start while a plane is still on");

endmodule

//--- rtl/screen_control.sv
module screen_control (
  input  logic                          clk,
  input  logic                          rst,
  input  hub75_pkg::panel_ctrl_t        ctrl,
  output logic                          shift_start,
  input  logic                          shift_done,
  output logic                          show_start,
  input  logic                          show_done,
  output logic [hub75_pkg::ROW_W-1:0]   row,
  output logic [hub75_pkg::PLANE_W-1:0] shift_plane,
  output logic [hub75_pkg::PLANE_W-1:0] show_plane,
  output logic                          lat,
  output logic                          frame_tick
);

  hub75_pkg::scan_state_t state;
  logic shift_busy;
  logic showing;
  logic last_latched;
  logic shift_ready;
  logic disp_idle;

  // done pulses count as free in their own cycle
  assign shift_ready = !shift_busy || shift_done;
  assign disp_idle   = !show_start && (!showing || show_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= hub75_pkg::SCAN_IDLE;
      row          <= '0;
      shift_plane  <= '0;
      show_plane   <= '0;
      shift_start  <= 1'b0;
      show_start   <= 1'b0;
      lat          <= 1'b0;
      frame_tick   <= 1'b0;
      shift_busy   <= 1'b0;
      showing      <= 1'b0;
      last_latched <= 1'b0;
    end else begin
      shift_start <= 1'b0;
      show_start  <= 1'b0;
      lat         <= 1'b0;
      frame_tick  <= 1'b0;

      if (shift_done) begin
        shift_busy <= 1'b0;
      end
      if (show_start) begin
        showing <= 1'b1;
      end else if (show_done) begin
        showing <= 1'b0;
      end

      case (state)
        hub75_pkg::SCAN_IDLE: begin
          if (ctrl.enable) begin
            row   <= '0;
            state <= hub75_pkg::SCAN_FIRST_SHIFT;
          end
        end
        hub75_pkg::SCAN_FIRST_SHIFT: begin
          shift_plane  <= '0;
          shift_start  <= 1'b1;
          shift_busy   <= 1'b1;
          last_latched <= 1'b0;
          state        <= hub75_pkg::SCAN_WAIT;
        end
        hub75_pkg::SCAN_WAIT: begin
          if (!ctrl.enable) begin
            // let the running plane finish, then stop
            if (disp_idle && shift_ready) begin
              state <= hub75_pkg::SCAN_IDLE;
            end
          end else if (last_latched) begin
            if (disp_idle) begin
              state <= hub75_pkg::SCAN_NEXT_ROW;
            end
          end else if (disp_idle && shift_ready) begin
            lat   <= 1'b1;
            state <= hub75_pkg::SCAN_LATCH;
          end
        end
        hub75_pkg::SCAN_LATCH: begin
          // show this plane while the next one shifts in
          show_start <= 1'b1;
          show_plane <= shift_plane;
          if (shift_plane == hub75_pkg::LAST_PLANE) begin
            last_latched <= 1'b1;
          end else begin
            shift_plane <= shift_plane + 1'b1;
            shift_start <= 1'b1;
            shift_busy  <= 1'b1;
          end
          state <= hub75_pkg::SCAN_WAIT;
        end
        hub75_pkg::SCAN_NEXT_ROW: begin
          if (row == hub75_pkg::LAST_ROW) begin
            row        <= '0;
            frame_tick <= 1'b1;
          end else begin
            row <= row + 1'b1;
          end
          state <= ctrl.enable ? hub75_pkg::SCAN_FIRST_SHIFT : hub75_pkg::SCAN_IDLE;
        end
        default: state <= hub75_pkg::SCAN_IDLE;
      endcase
    end
  end

  a_lat_blanked : assert property (
    @(posedge clk) disable iff (rst) lat |-> !showing
  ) else $error("lat while a plane is displayed");

  a_row_blanked : assert property (
    @(posedge clk) disable iff (rst) (row != $past(row)) |-> !showing
  ) else $error("row changed during display");

endmodule

//--- rtl/hub75_top.sv
module hub75_top (
  input  logic                  clk,
  input  logic                  rst,
  input  wb_pkg::wb_req_t       wb_req,
  output wb_pkg::wb_rsp_t       wb_rsp,
  output hub75_pkg::hub75_out_t hub75
);

  hub75_pkg::panel_ctrl_t        ctrl;
  logic                          frame_tick;
  logic                          fb_we;
  logic [hub75_pkg::FB_AW-1:0]   fb_waddr;
  hub75_pkg::pixel_t             fb_wdata;
  logic [hub75_pkg::FB_AW-1:0]   fb_raddr;
  hub75_pkg::pixel_t             fb_rdata;
  logic                          shift_start;
  logic                          shift_done;
  logic                          show_start;
  logic                          show_done;
  logic [hub75_pkg::ROW_W-1:0]   row;
  logic [hub75_pkg::PLANE_W-1:0] shift_plane;
  logic [hub75_pkg::PLANE_W-1:0] show_plane;
  hub75_pkg::rgb_bits_t          rgb;
  logic                          sclk;
  logic                          lat;
  logic                          oe_n;

  assign hub75 = '{rgb: rgb, sclk: sclk, lat: lat, oe_n: oe_n, row: row};

  panel_regs panel_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .ctrl       (ctrl),
    .frame_tick (frame_tick),
    .fb_we      (fb_we),
    .fb_waddr   (fb_waddr),
    .fb_wdata   (fb_wdata)
  );

  frame_buffer frame_buffer_inst (
    .clk   (clk),
    .we    (fb_we),
    .waddr (fb_waddr),
    .wdata (fb_wdata),
    .raddr (fb_raddr),
    .rdata (fb_rdata)
  );

  row_shifter row_shifter_inst (
    .clk         (clk),
    .rst         (rst),
    .shift_start (shift_start),
    .row         (row),
    .plane       (shift_plane),
    .raddr       (fb_raddr),
    .rdata       (fb_rdata),
    .rgb         (rgb),
    .sclk        (sclk),
    .shift_done  (shift_done)
  );

  bcm_timer bcm_timer_inst (
    .clk        (clk),
    .rst        (rst),
    .show_start (show_start),
    .plane      (show_plane),
    .dim        (ctrl.dim),
    .oe_n       (oe_n),
    .show_done  (show_done)
  );

  screen_control screen_control_inst (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .shift_start (shift_start),
    .shift_done  (shift_done),
    .show_start  (show_start),
    .show_done   (show_done),
    .row         (row),
    .shift_plane (shift_plane),
    .show_plane  (show_plane),
    .lat         (lat),
    .frame_tick  (frame_tick)
  );

endmodule

//--- tests/hub75_tb.sv
module hub75_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROW_CYCLES = hub75_pkg::PLANES * (hub75_pkg::SHIFT_STEPS + 4)
                            + (hub75_pkg::BCM_BASE << (hub75_pkg::PLANES - 1)) + 4;
  localparam int FRAME_CYCLES    = hub75_pkg::SCAN_ROWS * ROW_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * 2 * FRAME_CYCLES;

  logic                  clk;
  logic                  rst;
  wb_pkg::wb_req_t       wb_req;
  wb_pkg::wb_rsp_t       wb_rsp;
  hub75_pkg::hub75_out_t hub75;

  hub75_pkg::pixel_t             px [hub75_pkg::FB_DEPTH];
  hub75_pkg::rgb_bits_t          cap [hub75_pkg::PANEL_COLS];
  logic [31:0]                   rng;
  int                            errors;
  int                            latches_checked;
  int                            displays_timed;
  int                            cap_n;
  int                            low_run;
  int                            latch_count;
  logic                          model_on;
  logic                          dim_exp;
  logic                          run_pending;
  logic                          sclk_q;
  logic [hub75_pkg::ROW_W-1:0]   row_q;
  logic [hub75_pkg::ROW_W-1:0]   exp_row;
  logic [hub75_pkg::PLANE_W-1:0] exp_plane;
  logic [hub75_pkg::PLANE_W-1:0] shown_plane;

  hub75_top hub75_top_inst (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .hub75  (hub75)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // binary weighted on-time
  function automatic int on_cycles(input logic [hub75_pkg::PLANE_W-1:0] plane, input logic dim);
    int t;
    t = hub75_pkg::BCM_BASE << plane;
    if (dim) begin
      t = t / 2;
    end
    return t;
  endfunction

  function automatic hub75_pkg::rgb_bits_t expected_bits(
    input logic [hub75_pkg::ROW_W-1:0]   row,
    input logic [hub75_pkg::PLANE_W-1:0] plane,
    input logic [hub75_pkg::COL_W-1:0]   col
  );
    hub75_pkg::pixel_t    up;
    hub75_pkg::pixel_t    lo;
    hub75_pkg::rgb_bits_t bits;
    // lower half of the panel sits 32 rows further on
    up = px[{1'b0, row, col}];
    lo = px[{1'b1, row, col}];
    bits.r1 = up.r[plane];
    bits.g1 = up.g[plane];
    bits.b1 = up.b[plane];
    bits.r2 = lo.r[plane];
    bits.g2 = lo.g[plane];
    bits.b2 = lo.b[plane];
    return bits;
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // panel model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_display();
    if (!run_pending) begin
      report_fail("oe_n went low without a latch");
    end else if (low_run != on_cycles(shown_plane, dim_exp)) begin
      report_fail($sformatf("plane %0d on for %0d cycles, expected %0d",
                            shown_plane, low_run, on_cycles(shown_plane, dim_exp)));
    end
    displays_timed++;
    run_pending = 1'b0;
    low_run     = 0;
  endtask

  task automatic check_latch();
    hub75_pkg::rgb_bits_t want;
    if (cap_n != hub75_pkg::PANEL_COLS) begin
      report_fail($sformatf("%0d sclk pulses before lat, expected %0d",
                            cap_n, hub75_pkg::PANEL_COLS));
    end
    if (hub75.row != exp_row) begin
      report_fail($sformatf("lat on row %0d, expected row %0d", hub75.row, exp_row));
    end
    for (int c = 0; c < hub75_pkg::PANEL_COLS; c++) begin
      want = expected_bits(exp_row, exp_plane, c[hub75_pkg::COL_W-1:0]);
      if (cap[c] !== want) begin
        report_fail($sformatf("row %0d plane %0d col %0d: got %b, expected %b",
                              exp_row, exp_plane, c, cap[c], want));
      end
    end
    latches_checked++;
    latch_count++;
    shown_plane = exp_plane;
    run_pending = 1'b1;
    cap_n       = 0;
    if (exp_plane == hub75_pkg::LAST_PLANE) begin
      exp_plane = '0;
      exp_row   = (exp_row == hub75_pkg::LAST_ROW) ? '0 : exp_row + 1'b1;
    end else begin
      exp_plane = exp_plane + 1'b1;
    end
  endtask

  task automatic model_reset(input logic dim);
    cap_n       = 0;
    low_run     = 0;
    latch_count = 0;
    run_pending = 1'b0;
    exp_row     = '0;
    exp_plane   = '0;
    dim_exp     = dim;
    model_on    = 1'b1;
  endtask

  // sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (rst) begin
      sclk_q = 1'b0;
      row_q  = hub75.row;
    end else begin
      if (hub75.lat && !hub75.oe_n) begin
        report_fail("lat while oe_n is low");
      end
      if (hub75.row != row_q && !hub75.oe_n) begin
        report_fail("row changed while oe_n is low");
      end
      if (model_on) begin
        if (hub75.sclk && !sclk_q) begin
          if (cap_n < hub75_pkg::PANEL_COLS) begin
            cap[cap_n] = hub75.rgb;
          end
          cap_n++;
        end
        if (!hub75.oe_n) begin
          low_run++;
        end else if (low_run != 0) begin
          check_display();
        end
        if (hub75.lat) begin
          check_latch();
        end
      end
      sclk_q = hub75.sclk;
      row_q  = hub75.row;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int wait_n;
    @(posedge clk);
    #1;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat_w = wdata;
    wb_req.sel   = 4'hf;
    wait_n = 0;
    while (!wb_rsp.ack && wait_n < 16) begin
      @(posedge clk);
      #1;
      wait_n++;
    end
    if (!wb_rsp.ack) begin
      errors++;
      $display("no ack from the bus slave at offset %0h", adr);
    end else if (wait_n != 1) begin
      report_fail($sformatf("ack after %0d cycles, expected 1", wait_n));
    end
    rdata = wb_rsp.dat_r;
    // strobe kept up one more cycle must not bring a second ack
    @(posedge clk);
    #1;
    if (wb_rsp.ack) begin
      report_fail("second ack while stb is still high");
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    @(posedge clk);
    #1;
    if (wb_rsp.ack) begin
      report_fail("ack held for more than one cycle");
    end
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
    logic [31:0] discard;
    bus_cycle(1'b1, adr, data, discard);
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'd0, data);
  endtask

  task automatic wait_latches(input int n, input int limit);
    int k;
    k = 0;
    while (latch_count < n && k < limit) begin
      @(posedge clk);
      k++;
    end
    if (latch_count < n) begin
      report_timeout($sformatf("latch %0d, only %0d seen", n, latch_count));
    end
  endtask

  // quiet means blanked and no shift clock for longer than a shift
  task automatic wait_quiet(input int limit);
    int quiet;
    int k;
    quiet = 0;
    k     = 0;
    while (quiet < hub75_pkg::SHIFT_STEPS + 4 && k < limit) begin
      @(posedge clk);
      #1;
      quiet = (hub75.oe_n && !hub75.sclk) ? quiet + 1 : 0;
      k++;
    end
    if (quiet < hub75_pkg::SHIFT_STEPS + 4) begin
      report_timeout("the panel to go idle");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_registers();
    logic [31:0] rd;
    if (hub75.oe_n !== 1'b1 || hub75.lat !== 1'b0 || hub75.sclk !== 1'b0) begin
      report_fail("panel outputs not idle after reset");
    end
    wb_read(wb_pkg::REG_CTRL, rd);
    if (rd != 32'd0) begin
      report_fail($sformatf("CTRL reads %h after reset", rd));
    end
    wb_read(wb_pkg::REG_STATUS, rd);
    if (rd != 32'd0) begin
      report_fail($sformatf("STATUS reads %h after reset", rd));
    end
    // dim only, the sequencer stays off
    wb_write(wb_pkg::REG_CTRL, 32'h2);
    wb_read(wb_pkg::REG_CTRL, rd);
    if (rd != 32'h2) begin
      report_fail($sformatf("CTRL reads %h, expected 2", rd));
    end
    wb_write(wb_pkg::REG_CTRL, 32'h0);
    wb_read(wb_pkg::REG_CTRL, rd);
    if (rd != 32'h0) begin
      report_fail($sformatf("CTRL reads %h, expected 0", rd));
    end
  endtask

  task automatic fill_frame_buffer();
    logic [31:0] rd;
    wb_write(wb_pkg::REG_FB_ADDR, 32'd0);
    for (int i = 0; i < hub75_pkg::FB_DEPTH; i++) begin
      rng   = xorshift32(rng);
      px[i] = rng[11:0];
      wb_write(wb_pkg::REG_FB_DATA, {20'd0, rng[11:0]});
      // halfway, the window has stepped once per pixel
      if (i == hub75_pkg::FB_DEPTH / 2 - 1) begin
        wb_read(wb_pkg::REG_FB_ADDR, rd);
        if (rd != hub75_pkg::FB_DEPTH / 2) begin
          report_fail($sformatf("FB_ADDR reads %h after %0d pixels", rd, i + 1));
        end
      end
    end
    wb_read(wb_pkg::REG_FB_ADDR, rd);
    if (rd != 32'd0) begin
      report_fail($sformatf("FB_ADDR reads %h after a full fill, expected 0", rd));
    end
  endtask

  task automatic test_full_frame();
    logic [31:0] rd;
    int          k;
    model_reset(1'b0);
    wb_write(wb_pkg::REG_CTRL, 32'h1);
    wait_latches(hub75_pkg::SCAN_ROWS * hub75_pkg::PLANES, 2 * FRAME_CYCLES);
    k = 0;
    while (hub75.row != '0 && k < ROW_CYCLES) begin
      @(posedge clk);
      #1;
      k++;
    end
    if (hub75.row != '0) begin
      report_timeout("the row to wrap to 0");
    end
    wb_read(wb_pkg::REG_STATUS, rd);
    if (rd != 32'd1) begin
      report_fail($sformatf("STATUS reads %0d after one frame, expected 1", rd));
    end
  endtask

  task automatic test_disable();
    int bad;
    wb_write(wb_pkg::REG_CTRL, 32'h0);
    wait_quiet(4 * ROW_CYCLES);
    bad = 0;
    for (int i = 0; i < 500 && bad == 0; i++) begin
      @(posedge clk);
      #1;
      if (!hub75.oe_n || hub75.sclk || hub75.lat) begin
        report_fail("panel active while disabled");
        bad = 1;
      end
    end
  endtask

  // restarts at row 0 with every on-time halved
  task automatic test_dim();
    logic [31:0] rd;
    model_reset(1'b1);
    wb_write(wb_pkg::REG_CTRL, 32'h3);
    wb_read(wb_pkg::REG_CTRL, rd);
    if (rd != 32'h3) begin
      report_fail($sformatf("CTRL reads %h, expected 3", rd));
    end
    wait_latches(2 * hub75_pkg::PLANES, 4 * ROW_CYCLES);
    wb_write(wb_pkg::REG_CTRL, 32'h0);
    wait_quiet(4 * ROW_CYCLES);
  endtask

  initial begin
    rst             = 1'b1;
    wb_req          = '0;
    rng             = 32'hde8a_7241;
    errors          = 0;
    latches_checked = 0;
    displays_timed  = 0;
    latch_count     = 0;
    cap_n           = 0;
    low_run         = 0;
    model_on        = 1'b0;
    dim_exp         = 1'b0;
    run_pending     = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    test_registers();
    fill_frame_buffer();
    test_full_frame();
    test_disable();
    test_dim();
    if (displays_timed != latches_checked) begin
      report_fail($sformatf("%0d planes latched but %0d displayed",
                            latches_checked, displays_timed));
    end
    $display("%0d latches checked, %0d displays timed, %0d errors",
             latches_checked, displays_timed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/hub75_pkg.sv
rtl/wb_pkg.sv
rtl/panel_regs.sv
rtl/frame_buffer.sv
rtl/row_shifter.sv
rtl/bcm_timer.sv
rtl/screen_control.sv
rtl/hub75_top.sv
tests/hub75_tb.sv

//--- Makefile
TOP := hub75_tb

.PHONY: sim clean

# build, run, and pass only when the run reports success
sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
